/* digit_scanner.sv */
`timescale 1ns/1ps
`include "seg_params.svh"

module digit_scanner (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  seg_pkg::display_value_t display_value,
    input  logic                    busy,
    output logic                    update,
    output seg_pkg::digit_req_t     digit_req
);
    import seg_pkg::*;

    localparam int DWELL_CLKS = `SEG_DWELL_CLKS;
    localparam int DWELL_W    = $clog2(DWELL_CLKS + 1);

    scan_state_t        state;
    display_value_t     value_q;
    digit_idx_t         digit_cnt;
    logic [DWELL_W-1:0] dwell_cnt;
    logic               dwell_done;
    logic               scan_start;
    logic               advance;
    nibble_t            cur_nibble;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // counter holds cycles since the last update, saturating at the dwell
    assign dwell_done = (dwell_cnt == DWELL_W'(DWELL_CLKS - 1));

    assign scan_start = (state == st_idle) && enable;
    assign advance    = (state == st_dwell) && enable && dwell_done && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            digit_cnt <= '0;
            dwell_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (scan_start) begin
                        state     <= st_issue;
                        digit_cnt <= '0;
                    end
                end
                st_issue: begin
                    state     <= st_dwell;
                    dwell_cnt <= DWELL_W'(1);
                end
                st_dwell: begin
                    if (!dwell_done) begin
                        dwell_cnt <= dwell_cnt + 1'b1;
                    end
                    if (!enable) begin
                        // let the frame in flight finish before parking
                        if (!busy) begin
                            state <= st_idle;
                        end
                    end else if (advance) begin
                        state     <= st_issue;
                        digit_cnt <= digit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // new value is taken at scan start and whenever digit 0 comes round again
    always_ff @(posedge clk) begin
        if (scan_start || (advance && digit_cnt == 2'd3)) begin
            value_q <= display_value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request to the shifter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // digit 0 is the top nibble
    always_comb begin
        case (digit_cnt)
            2'd0:    cur_nibble = value_q[15:12];
            2'd1:    cur_nibble = value_q[11:8];
            2'd2:    cur_nibble = value_q[7:4];
            default: cur_nibble = value_q[3:0];
        endcase
    end

    assign digit_req.idx   = digit_cnt;
    assign digit_req.value = cur_nibble;

    // one-cycle strobe, the issue state lasts a single cycle
    assign update = (state == st_issue);

endmodule

/* hc595_shifter.sv */
`timescale 1ns/1ps
`include "seg_params.svh"

module hc595_shifter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                update,
    input  seg_pkg::digit_req_t digit_req,
    output logic                busy,
    output logic                ds_data,
    output logic                ds_shcp,
    output logic                ds_stcp
);
    import seg_pkg::*;

    localparam int BIT_CLKS   = `SEG_BIT_CLKS;
    localparam int FRAME_BITS = `SEG_FRAME_BITS;
    localparam int CNT_W      = $clog2(BIT_CLKS);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    ds_frame_t        frame_q;
    seg_pattern_t     pattern;
    logic [3:0]       select_n;
    logic             start;

    logic [CNT_W-1:0] clk_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             bit_end;
    logic             frame_end;
    logic             stcp_arm;

    // common-cathode patterns, decimal point kept dark
    function automatic seg_pattern_t hex_to_seg(input nibble_t n);
        case (n)
            4'h0:    hex_to_seg = 8'h3f;
            4'h1:    hex_to_seg = 8'h06;
            4'h2:    hex_to_seg = 8'h5b;
            4'h3:    hex_to_seg = 8'h4f;
            4'h4:    hex_to_seg = 8'h66;
            4'h5:    hex_to_seg = 8'h6d;
            4'h6:    hex_to_seg = 8'h7d;
            4'h7:    hex_to_seg = 8'h07;
            4'h8:    hex_to_seg = 8'h7f;
            4'h9:    hex_to_seg = 8'h6f;
            4'ha:    hex_to_seg = 8'h77;
            4'hb:    hex_to_seg = 8'h7c;
            4'hc:    hex_to_seg = 8'h39;
            4'hd:    hex_to_seg = 8'h5e;
            4'he:    hex_to_seg = 8'h79;
            default: hex_to_seg = 8'h71;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // requests arriving mid-frame are dropped
    assign start = update && !busy;

    assign pattern  = hex_to_seg(digit_req.value);
    // digit k pulls select bit 3-k low
    assign select_n = ~(4'b0001 << (2'd3 - digit_req.idx));

    always_ff @(posedge clk) begin
        if (start) begin
            frame_q <= {pattern, 4'b0000, select_n};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign bit_end   = busy && (clk_cnt == CNT_W'(BIT_CLKS - 1));
    assign frame_end = bit_end && (bit_cnt == BIT_W'(FRAME_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                clk_cnt <= '0;
                bit_cnt <= frame_end ? '0 : bit_cnt + 1'b1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            if (frame_end) begin
                busy <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // serial lines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data moves a quarter bit in, msb first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_data <= 1'b0;
        end else if (busy && clk_cnt == CNT_W'(BIT_CLKS / 4 - 1)) begin
            ds_data <= frame_q[BIT_W'(FRAME_BITS - 1) - bit_cnt];
        end
    end

    // shift clock high for the second half of every bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_shcp <= 1'b0;
        end else if (busy && clk_cnt == CNT_W'(BIT_CLKS / 2 - 1)) begin
            ds_shcp <= 1'b1;
        end else if (bit_end) begin
            ds_shcp <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stcp_arm <= 1'b0;
        end else begin
            stcp_arm <= frame_end;
        end
    end

    // latch pulse one cycle after the last bit, held until the next frame's first bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_stcp <= 1'b0;
        end else if (stcp_arm) begin
            ds_stcp <= 1'b1;
        end else if (bit_end && bit_cnt == '0) begin
            ds_stcp <= 1'b0;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module seg_display_tb \
    -f src.f -o seg_display_sim || { echo "build error"; exit 1; }
./obj_dir/seg_display_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "result: FAIL"; exit 1; }
echo "result: PASS"

/* seg_display_checker.sv */
`timescale 1ns/1ps
`include "seg_params.svh"

module seg_display_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    enable,
    input seg_pkg::display_value_t display_value,
    input logic                    ds_data,
    input logic                    ds_shcp,
    input logic                    ds_stcp
);
    import seg_pkg::*;

    localparam int FRAME_BITS = `SEG_FRAME_BITS;

    // common-cathode segments g..a for 0..F
    localparam seg_pattern_t SEG_TABLE [16] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
        8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71
    };

    logic           shcp_q;
    logic           stcp_q;
    logic           enable_q;
    logic           shcp_rise;
    logic           stcp_rise;
    logic           enable_rise;
    logic           enable_fall;
    ds_frame_t      shift_q;
    logic [4:0]     shcp_cnt;
    digit_idx_t     exp_idx;
    display_value_t value_q;
    logic           started;
    logic [1:0]     late_frames;
    nibble_t        exp_nibble;
    ds_frame_t      exp_frame;
    int             err_cnt = 0;

    assign shcp_rise   = ds_shcp && !shcp_q;
    assign stcp_rise   = ds_stcp && !stcp_q;
    assign enable_rise = enable && !enable_q;
    assign enable_fall = !enable && enable_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame capture and prediction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shcp_q      <= 1'b0;
            stcp_q      <= 1'b0;
            enable_q    <= 1'b0;
            shift_q     <= '0;
            shcp_cnt    <= '0;
            exp_idx     <= '0;
            value_q     <= '0;
            started     <= 1'b0;
            late_frames <= '0;
        end else begin
            shcp_q   <= ds_shcp;
            stcp_q   <= ds_stcp;
            enable_q <= enable;
            // the chain shifts on the rising shift clock, msb arrives first
            if (shcp_rise) begin
                shift_q <= {shift_q[14:0], ds_data};
            end
            if (stcp_rise) begin
                shcp_cnt <= '0;
            end else if (shcp_rise && shcp_cnt != '1) begin
                shcp_cnt <= shcp_cnt + 1'b1;
            end
            if (enable_rise) begin
                exp_idx <= '0;
                value_q <= display_value;
                started <= 1'b1;
            end else if (stcp_rise) begin
                exp_idx <= exp_idx + 1'b1;
            end
            if (enable_fall) begin
                late_frames <= '0;
            end else if (stcp_rise && !enable && late_frames != '1) begin
                late_frames <= late_frames + 1'b1;
            end
        end
    end

    assign exp_nibble = value_q[4 * (3 - exp_idx) +: 4];
    assign exp_frame  = {SEG_TABLE[exp_nibble], 4'h0, 4'b1111 ^ (4'b1000 >> exp_idx)};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !ds_data && !ds_shcp && !ds_stcp)
    else begin
        err_cnt++;
        $error("serial lines active before the first scan");
    end

    a_shcp_count: assert property (@(posedge clk) disable iff (!rst_n)
        stcp_rise |-> shcp_cnt == 5'(FRAME_BITS))
    else begin
        err_cnt++;
        $error("Fail shcp_count %h expected %h", $sampled(shcp_cnt), FRAME_BITS);
    end

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        shcp_rise |-> $stable(ds_data))
    else begin
        err_cnt++;
        $error("ds_data changed on a rising edge of ds_shcp");
    end

    a_select_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        stcp_rise |-> $onehot(~shift_q[3:0]))
    else begin
        err_cnt++;
        $error("Fail select %h", $sampled(shift_q[3:0]));
    end

    // digit order, segments and the zero gap in one compare
    a_frame_value: assert property (@(posedge clk) disable iff (!rst_n)
        stcp_rise |-> shift_q == exp_frame)
    else begin
        err_cnt++;
        $error("Fail ds_frame %h expected %h", $sampled(shift_q), $sampled(exp_frame));
    end

    a_stop_one_frame: assert property (@(posedge clk) disable iff (!rst_n)
        stcp_rise && !enable |-> late_frames == '0)
    else begin
        err_cnt++;
        $error("more than one frame latched after enable fell");
    end

endmodule

/* seg_display_tb.sv */
`timescale 1ns/1ps
`include "seg_params.svh"

module seg_display_tb;
    import seg_pkg::*;

    localparam int PHASES      = 12;
    localparam int SWEEPS      = 3;
    localparam int FRAME_CLKS  = `SEG_FRAME_BITS * `SEG_BIT_CLKS;
    localparam int WATCHDOG_NS = PHASES * SWEEPS * 4 * `SEG_DWELL_CLKS * 40 * 11 / 10;

    logic           clk;
    logic           rst_n;
    logic           enable;
    display_value_t display_value;
    logic           ds_data;
    logic           ds_shcp;
    logic           ds_stcp;
    logic [31:0]    rng;

    tb_clock_gen i_clk_gen (
        .clk (clk)
    );

    seg_display_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .display_value (display_value),
        .ds_data       (ds_data),
        .ds_shcp       (ds_shcp),
        .ds_stcp       (ds_stcp)
    );

    bind seg_display_top seg_display_checker i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .display_value (display_value),
        .ds_data       (ds_data),
        .ds_shcp       (ds_shcp),
        .ds_stcp       (ds_stcp)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // waits on the serial lines, sampled on the falling clock
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_shcp_quiet();
        int quiet;
        quiet = 0;
        while (quiet < FRAME_CLKS) begin
            @(negedge clk);
            quiet = ds_shcp ? 0 : quiet + 1;
        end
    endtask

    task automatic wait_stcp_rises(input int count);
        int   seen;
        logic prev;
        seen = 0;
        @(negedge clk);
        prev = ds_stcp;
        while (seen < count) begin
            @(negedge clk);
            if (ds_stcp && !prev) begin
                seen++;
            end
            prev = ds_stcp;
        end
    endtask

    // stop either between frames or while the last frame is still shifting
    task automatic run_phase(input display_value_t value, input logic stop_in_frame);
        @(posedge clk);
        enable <= 1'b0;
        wait_shcp_quiet();
        @(posedge clk);
        display_value <= value;
        enable        <= 1'b1;
        if (stop_in_frame) begin
            wait_stcp_rises(SWEEPS * 4 - 1);
            do @(negedge clk); while (ds_stcp);
        end else begin
            wait_stcp_rises(SWEEPS * 4);
        end
    endtask

    initial begin
        display_value_t value;
        logic [3:0]     offset;
        rst_n         = 1'b0;
        enable        = 1'b0;
        display_value = '0;
        rng           = 32'h3d41;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        rng    = next_random(rng);
        offset = rng[3:0];
        for (int p = 0; p < PHASES; p++) begin
            rng = next_random(rng);
            if (p < 4) begin
                // four consecutive nibbles per phase, so 0..F all show up
                for (int k = 0; k < 4; k++) begin
                    value[15 - 4 * k -: 4] = 4'(4 * p + k + offset);
                end
            end else begin
                value = rng[15:0];
            end
            run_phase(value, rng[16]);
        end
        @(posedge clk);
        enable <= 1'b0;
        wait_shcp_quiet();

        if (i_dut.i_checker.err_cnt == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "checker assertions failed");
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_checker.err_cnt != 0) begin
            $display("Something failed");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation timed out");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* seg_display_top.sv */
`timescale 1ns/1ps

module seg_display_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  seg_pkg::display_value_t display_value,
    output logic                    ds_data,
    output logic                    ds_shcp,
    output logic                    ds_stcp
);
    import seg_pkg::*;

    digit_req_t digit_req;
    logic       update;
    logic       busy;

    // picks the digit and paces the scan
    digit_scanner i_scanner (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .display_value (display_value),
        .busy          (busy),
        .update        (update),
        .digit_req     (digit_req)
    );

    // drives the 74HC595 chain
    hc595_shifter i_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .update    (update),
        .digit_req (digit_req),
        .busy      (busy),
        .ds_data   (ds_data),
        .ds_shcp   (ds_shcp),
        .ds_stcp   (ds_stcp)
    );

endmodule

/* seg_params.svh */
`ifndef SEG_PARAMS_SVH
`define SEG_PARAMS_SVH

// clock cycles spent on one serial bit of the 74HC595 chain
`define SEG_BIT_CLKS 24

// bits in one frame, two chained 8-bit registers
`define SEG_FRAME_BITS 16

// cycles from one digit update to the next
// must stay above SEG_FRAME_BITS * SEG_BIT_CLKS so a frame always completes
`define SEG_DWELL_CLKS 500

`endif

/* seg_pkg.sv */
package seg_pkg;

    // digit number, 0 is the leftmost digit
    typedef logic [1:0]  digit_idx_t;

    // one hex digit
    typedef logic [3:0]  nibble_t;

    // segments g..a in bits 6..0, bit 7 is the decimal point
    typedef logic [7:0]  seg_pattern_t;

    // four nibbles, digit 0 in bits 15..12
    typedef logic [15:0] display_value_t;

    // serial frame: pattern in 15..8, zero in 7..4, active-low select in 3..0
    typedef logic [15:0] ds_frame_t;

    typedef struct packed {
        digit_idx_t idx;
        nibble_t    value;
    } digit_req_t;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_dwell
    } scan_state_t;

endpackage

/* src.f */
+incdir+.
seg_pkg.sv
hc595_shifter.sv
digit_scanner.sv
seg_display_top.sv
seg_display_checker.sv
tb_clock_gen.sv
seg_display_tb.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule
